// ==== project.f ====
+incdir+.
mem_pipe_pkg.sv
mem_req_stage.sv
read_wait_stage.sv
writeback_stage.sv
mem_pipe_top.sv
tb_mem_pipe.sv

// ==== tb_mem_model.svh ====
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

// program-order copy of the bus memory
logic [31:0] model_mem [0:255];

// expected retirements in issue order
logic [31:0] exp_pc_q[$];
logic        exp_exc_q[$];
logic        exp_we_q[$];
logic [4:0]  exp_waddr_q[$];
logic [31:0] exp_wdata_q[$];
// byte addresses of the bus requests still to come
logic [31:0] exp_req_q[$];
// direction and size of those same requests
logic        exp_wr_q[$];
logic [1:0]  exp_size_q[$];

function automatic logic [31:0] fill_word(input logic [7:0] idx);
    return {idx, ~idx, idx ^ 8'h5a, idx + 8'h37};
endfunction

task automatic model_issue(input mem_op_e op, input logic [31:0] pc, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [4:0] dest);
    logic [31:0] word;
    logic [7:0]  b;
    logic [15:0] h;
    logic        is_ld;
    logic        is_st;
    logic        bad;
    logic [31:0] res;
    logic [1:0]  sz;
    is_ld = op inside {OP_LD_B, OP_LD_BU, OP_LD_H, OP_LD_HU, OP_LD_W};
    is_st = op inside {OP_ST_B, OP_ST_H, OP_ST_W};
    bad   = ((op inside {OP_LD_H, OP_LD_HU, OP_ST_H}) && addr[0]) ||
            ((op inside {OP_LD_W, OP_ST_W}) && addr[1:0] != 2'b00);
    sz    = (op inside {OP_LD_B, OP_LD_BU, OP_ST_B}) ? 2'd0 :
            (op inside {OP_LD_H, OP_LD_HU, OP_ST_H}) ? 2'd1 : 2'd2;
    word  = model_mem[addr[9:2]];
    b     = word[{addr[1:0], 3'b000} +: 8];
    h     = word[{addr[1], 4'b0000} +: 16];
    case (op)
        OP_LD_B:  res = {{24{b[7]}}, b};
        OP_LD_BU: res = {24'd0, b};
        OP_LD_H:  res = {{16{h[15]}}, h};
        OP_LD_HU: res = {16'd0, h};
        OP_LD_W:  res = word;
        default:  res = addr;
    endcase
    if (!bad) begin
        case (op)
            OP_ST_B: model_mem[addr[9:2]][{addr[1:0], 3'b000} +: 8] = wdata[7:0];
            OP_ST_H: model_mem[addr[9:2]][{addr[1], 4'b0000} +: 16] = wdata[15:0];
            OP_ST_W: model_mem[addr[9:2]] = wdata;
            default: ;
        endcase
        if (is_ld || is_st) begin
            exp_req_q.push_back(addr);
            exp_wr_q.push_back(is_st);
            exp_size_q.push_back(sz);
        end
    end
    exp_pc_q.push_back(pc);
    exp_exc_q.push_back(bad);
    exp_we_q.push_back((is_ld || op == OP_ALU) && !bad && dest != 5'd0);
    exp_waddr_q.push_back(dest);
    exp_wdata_q.push_back(res);
endtask

`endif

// ==== tb_mem_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_pipe;
    import mem_pipe_pkg::*;

    localparam int NUM_INSTR  = 400;
    localparam int MAX_CYCLES = 20000;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] in_pc;
    mem_op_e     in_op;
    logic [31:0] in_addr;
    logic [31:0] in_wdata;
    logic [4:0]  in_dest;
    logic        wb_ready;
    logic        data_req;
    logic        data_wr;
    logic [1:0]  data_size;
    logic [3:0]  data_wstrb;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic        addr_ok;
    logic        data_ok;
    logic [31:0] data_rdata;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic        retire_exc;
    logic [5:0]  retire_ecode;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;

    logic [31:0] lfsr;
    logic [31:0] bus_mem [0:255];
    logic [31:0] resp_data_q[$];
    int          resp_due_q[$];
    logic        taken;
    int          mismatches;
    int          failures;
    int          cyc;
    int          sent;
    int          i;

    `include "tb_mem_model.svh"

    mem_pipe_top dut_i (.*);

    always #20 clk = ~clk;

    // galois lfsr stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        int          k;
        v = '0;
        for (k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (exp !== act) begin
            mismatches++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic next_instr();
        logic [7:0] offs;
        in_op    = mem_op_e'(4'(take_bits(4) % 9));
        in_pc    = 32'h1c00_0000 + 32'(sent) * 4;
        in_wdata = take_bits(32);
        in_dest  = 5'(take_bits(5));
        offs     = 8'(take_bits(8));
        // mostly aligned so that loads and stores reach the bus
        if (take_bits(2) != 0) begin
            if (in_op inside {OP_LD_H, OP_LD_HU, OP_ST_H}) begin
                offs[0] = 1'b0;
            end
            if (in_op inside {OP_LD_W, OP_ST_W}) begin
                offs[1:0] = 2'b00;
            end
        end
        in_addr = (in_op == OP_ALU) ? take_bits(32) : {24'd0, offs};
    endtask

    task automatic sample_cycle();
        logic [31:0] word;
        logic        exc;
        logic        we;
        int          k;
        if (in_valid && in_ready) begin
            model_issue(in_op, in_pc, in_addr, in_wdata, in_dest);
            sent++;
            taken = 1'b1;
        end
        if (retire_valid && wb_ready) begin
            if (exp_pc_q.size() == 0) begin
                failures++;
                $display("retirement of pc %h with no instruction outstanding", retire_pc);
            end else begin
                exc = exp_exc_q.pop_front();
                we  = exp_we_q.pop_front();
                compare_value("retire_pc", exp_pc_q.pop_front(), retire_pc);
                compare_value("retire_exc", exc, retire_exc);
                compare_value("retire_ecode", exc ? 32'(ECODE_ALE) : 32'd0, retire_ecode);
                compare_value("rf_we", we, rf_we);
                if (we) begin
                    compare_value("rf_waddr", exp_waddr_q.pop_front(), rf_waddr);
                    compare_value("rf_wdata", exp_wdata_q.pop_front(), rf_wdata);
                end else begin
                    exp_waddr_q.delete(0);
                    exp_wdata_q.delete(0);
                end
            end
        end
        if (data_ok) begin
            resp_data_q.delete(0);
            resp_due_q.delete(0);
        end
        // responder side of the bus handshake
        if (data_req && addr_ok) begin
            if (exp_req_q.size() == 0) begin
                failures++;
                $display("bus request to %h that no instruction should issue", data_addr);
            end else begin
                compare_value("bus_addr", exp_req_q.pop_front(), data_addr);
                compare_value("bus_wr", exp_wr_q.pop_front(), data_wr);
                compare_value("bus_size", exp_size_q.pop_front(), data_size);
            end
            word = bus_mem[data_addr[9:2]];
            for (k = 0; k < 4; k++) begin
                if (data_wr && data_wstrb[k]) begin
                    word[8*k +: 8] = data_wdata[8*k +: 8];
                end
            end
            bus_mem[data_addr[9:2]] = word;
            resp_data_q.push_back(word);
            resp_due_q.push_back(cyc + 1 + int'(take_bits(2)));
        end
    endtask

    task automatic drive_cycle();
        cyc++;
        if (!in_valid || taken) begin
            in_valid = 1'b0;
            if (sent < NUM_INSTR && take_bits(2) != 0) begin
                next_instr();
                in_valid = 1'b1;
            end
        end
        taken    = 1'b0;
        wb_ready = take_bits(2) != 0;
        addr_ok  = take_bits(1) != 0;
        data_ok  = 1'b0;
        if (resp_due_q.size() != 0) begin
            data_ok = resp_due_q[0] <= cyc;
        end
        data_rdata = data_ok ? resp_data_q[0] : 32'h0;
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_pc      = '0;
        in_op      = OP_ALU;
        in_addr    = '0;
        in_wdata   = '0;
        in_dest    = '0;
        wb_ready   = 1'b0;
        addr_ok    = 1'b0;
        data_ok    = 1'b0;
        data_rdata = '0;
        lfsr       = 32'd92886;
        taken      = 1'b0;
        mismatches = 0;
        failures   = 0;
        cyc        = 0;
        sent       = 0;
        for (i = 0; i < 256; i++) begin
            bus_mem[i]   = fill_word(8'(i));
            model_mem[i] = fill_word(8'(i));
        end
        repeat (4) @(posedge clk);
        #2;
        rst      = 1'b0;
        wb_ready = 1'b1;
        // quiet outputs before the first instruction
        repeat (3) begin
            @(negedge clk);
            compare_value("idle_data_req", 32'd0, data_req);
            compare_value("idle_retire_valid", 32'd0, retire_valid);
        end
        while ((sent < NUM_INSTR || exp_pc_q.size() != 0) && cyc < MAX_CYCLES) begin
            @(negedge clk);
            sample_cycle();
            @(posedge clk);
            #2;
            drive_cycle();
        end
        if (sent < NUM_INSTR || exp_pc_q.size() != 0) begin
            failures++;
            $display("timeout after %0d cycles: %0d instructions accepted, %0d not retired",
                     cyc, sent, exp_pc_q.size());
        end
        if (exp_req_q.size() != 0) begin
            failures++;
            $display("%0d expected bus requests were never issued", exp_req_q.size());
        end
        $display("errors: %0d value mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mem_pipe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_pipe_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [31:0]           in_pc,
    input  mem_pipe_pkg::mem_op_e in_op,
    input  logic [31:0]           in_addr,
    input  logic [31:0]           in_wdata,
    input  logic [4:0]            in_dest,
    input  logic                  wb_ready,
    output logic                  data_req,
    output logic                  data_wr,
    output logic [1:0]            data_size,
    output logic [3:0]            data_wstrb,
    output logic [31:0]           data_addr,
    output logic [31:0]           data_wdata,
    input  logic                  addr_ok,
    input  logic                  data_ok,
    input  logic [31:0]           data_rdata,
    output logic                  retire_valid,
    output logic [31:0]           retire_pc,
    output logic                  retire_exc,
    output logic [5:0]            retire_ecode,
    output logic                  rf_we,
    output logic [4:0]            rf_waddr,
    output logic [31:0]           rf_wdata
);
    import mem_pipe_pkg::*;

    // request stage to read-wait stage
    logic        req_valid;
    logic        req_ready;
    logic [31:0] req_pc;
    logic [31:0] req_result;
    mem_op_e     req_op;
    logic [1:0]  req_offset;
    logic [4:0]  req_dest;
    logic        req_has_req;
    logic        req_exc;
    logic [5:0]  req_ecode;

    // read-wait stage to writeback
    logic        rw_valid;
    logic        rw_ready;
    logic [31:0] rw_pc;
    logic [31:0] rw_result;
    logic [31:0] rw_rdata;
    mem_op_e     rw_op;
    logic [1:0]  rw_offset;
    logic [4:0]  rw_dest;
    logic        rw_exc;
    logic [5:0]  rw_ecode;

    mem_req_stage req_i (
        .clk, .rst, .in_valid, .in_ready,
        .in_pc, .in_addr, .in_wdata, .in_op, .in_dest,
        .out_ready   (req_ready),
        .out_valid   (req_valid),
        .out_pc      (req_pc),
        .out_result  (req_result),
        .out_op      (req_op),
        .out_offset  (req_offset),
        .out_dest    (req_dest),
        .out_has_req (req_has_req),
        .out_exc     (req_exc),
        .out_ecode   (req_ecode),
        .data_req, .data_wr, .data_size, .data_wstrb,
        .data_addr, .data_wdata, .addr_ok
    );

    read_wait_stage rw_i (
        .clk, .rst,
        .in_valid    (req_valid),
        .in_ready    (req_ready),
        .out_ready   (rw_ready),
        .out_valid   (rw_valid),
        .in_pc       (req_pc),
        .in_result   (req_result),
        .in_op       (req_op),
        .in_offset   (req_offset),
        .in_dest     (req_dest),
        .in_has_req  (req_has_req),
        .in_exc      (req_exc),
        .in_ecode    (req_ecode),
        .data_ok, .data_rdata,
        .out_pc      (rw_pc),
        .out_result  (rw_result),
        .out_rdata   (rw_rdata),
        .out_op      (rw_op),
        .out_offset  (rw_offset),
        .out_dest    (rw_dest),
        .out_exc     (rw_exc),
        .out_ecode   (rw_ecode)
    );

    writeback_stage wb_i (
        .clk, .rst,
        .in_valid    (rw_valid),
        .in_ready    (rw_ready),
        .in_pc       (rw_pc),
        .in_result   (rw_result),
        .in_rdata    (rw_rdata),
        .in_op       (rw_op),
        .in_offset   (rw_offset),
        .in_dest     (rw_dest),
        .in_exc      (rw_exc),
        .in_ecode    (rw_ecode),
        .wb_ready,
        .retire_valid, .retire_pc, .retire_exc, .retire_ecode,
        .rf_we, .rf_waddr, .rf_wdata
    );

endmodule

`default_nettype wire

// ==== writeback_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [31:0]           in_pc,
    input  logic [31:0]           in_result,
    input  logic [31:0]           in_rdata,
    input  mem_pipe_pkg::mem_op_e in_op,
    input  logic [1:0]            in_offset,
    input  logic [4:0]            in_dest,
    input  logic                  in_exc,
    input  logic [5:0]            in_ecode,
    input  logic                  wb_ready,
    output logic                  retire_valid,
    output logic [31:0]           retire_pc,
    output logic                  retire_exc,
    output logic [5:0]            retire_ecode,
    output logic                  rf_we,
    output logic [4:0]            rf_waddr,
    output logic [31:0]           rf_wdata
);
    import mem_pipe_pkg::*;

    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    logic [31:0] wb_data;
    logic        we;
    logic        fwd;

    assign in_ready = !rst && (!in_valid || wb_ready);
    assign fwd      = in_valid && wb_ready;

    // lane select by byte offset
    assign ld_byte = in_rdata[{in_offset, 3'b000} +: 8];
    assign ld_half = in_rdata[{in_offset[1], 4'b0000} +: 16];

    always_comb begin
        case (in_op)
            OP_LD_B:  wb_data = {{24{ld_byte[7]}}, ld_byte};
            OP_LD_BU: wb_data = {24'd0, ld_byte};
            OP_LD_H:  wb_data = {{16{ld_half[15]}}, ld_half};
            OP_LD_HU: wb_data = {16'd0, ld_half};
            OP_LD_W:  wb_data = in_rdata;
            default:  wb_data = in_result;
        endcase
    end

    assign we = !in_exc && (in_dest != 5'd0) && (op_is_load(in_op) || in_op == OP_ALU);

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
            rf_we        <= 1'b0;
        end else if (wb_ready) begin
            retire_valid <= in_valid;
            rf_we        <= in_valid && we;
        end
    end

    always_ff @(posedge clk) begin
        if (fwd) begin
            retire_pc    <= in_pc;
            retire_exc   <= in_exc;
            retire_ecode <= in_ecode;
            rf_waddr     <= in_dest;
            rf_wdata     <= wb_data;
        end
    end

endmodule

`default_nettype wire

// ==== read_wait_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module read_wait_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic                  out_ready,
    output logic                  out_valid,
    input  logic [31:0]           in_pc,
    input  logic [31:0]           in_result,
    input  mem_pipe_pkg::mem_op_e in_op,
    input  logic [1:0]            in_offset,
    input  logic [4:0]            in_dest,
    input  logic                  in_has_req,
    input  logic                  in_exc,
    input  logic [5:0]            in_ecode,
    input  logic                  data_ok,
    input  logic [31:0]           data_rdata,
    output logic [31:0]           out_pc,
    output logic [31:0]           out_result,
    output logic [31:0]           out_rdata,
    output mem_pipe_pkg::mem_op_e out_op,
    output logic [1:0]            out_offset,
    output logic [4:0]            out_dest,
    output logic                  out_exc,
    output logic [5:0]            out_ecode
);
    import mem_pipe_pkg::*;

    logic        ready_go;
    logic        fwd;
    logic        consume;
    logic        pop;
    logic        push;
    logic        data_valid;
    logic [31:0] data;
    logic        data1_valid;
    logic [31:0] data1;
    logic [31:0] fwd_data;

    assign ready_go = !in_valid || !in_has_req || data_valid || data_ok;
    assign fwd      = in_valid && ready_go && out_ready;
    assign in_ready = !rst && (!in_valid || ready_go && out_ready);

    // the oldest held word belongs to the instruction in this stage
    assign consume  = fwd && in_has_req;
    assign pop      = consume && data_valid;
    assign push     = data_ok && !(consume && !data_valid);
    assign fwd_data = data_valid ? data : data_rdata;

    // second slot covers the response of the request issued behind us
    always_ff @(posedge clk) begin
        if (rst) begin
            data_valid  <= 1'b0;
            data1_valid <= 1'b0;
        end else if (pop && !push) begin
            data_valid  <= data1_valid;
            data1_valid <= 1'b0;
        end else if (push && !pop) begin
            data_valid  <= 1'b1;
            data1_valid <= data_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            data  <= data1_valid ? data1 : data_rdata;
            data1 <= data_rdata;
        end else if (push && data_valid) begin
            data1 <= data_rdata;
        end else if (push) begin
            data <= data_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (out_ready) begin
            out_valid <= in_valid && ready_go;
        end
    end

    always_ff @(posedge clk) begin
        if (fwd) begin
            out_pc     <= in_pc;
            out_result <= in_result;
            out_rdata  <= fwd_data;
            out_op     <= in_op;
            out_offset <= in_offset;
            out_dest   <= in_dest;
            out_exc    <= in_exc;
            out_ecode  <= in_ecode;
        end
    end

    // request stage never lets more than two responses be outstanding
    assert property (@(posedge clk) disable iff (rst)
        data_ok |-> !(data_valid && data1_valid));

endmodule

`default_nettype wire

// ==== mem_req_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_req_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [31:0]           in_pc,
    input  logic [31:0]           in_addr,
    input  logic [31:0]           in_wdata,
    input  mem_pipe_pkg::mem_op_e in_op,
    input  logic [4:0]            in_dest,
    input  logic                  out_ready,
    output logic                  out_valid,
    output logic [31:0]           out_pc,
    output logic [31:0]           out_result,
    output mem_pipe_pkg::mem_op_e out_op,
    output logic [1:0]            out_offset,
    output logic [4:0]            out_dest,
    output logic                  out_has_req,
    output logic                  out_exc,
    output logic [5:0]            out_ecode,
    output logic                  data_req,
    output logic                  data_wr,
    output logic [1:0]            data_size,
    output logic [3:0]            data_wstrb,
    output logic [31:0]           data_addr,
    output logic [31:0]           data_wdata,
    input  logic                  addr_ok
);
    import mem_pipe_pkg::*;

    typedef enum logic [1:0] {IDLE, REQ, SENT} req_state_e;

    req_state_e  state;
    logic        valid_q;
    logic [31:0] pc_q;
    logic [31:0] addr_q;
    logic [31:0] wdata_q;
    mem_op_e     op_q;
    logic [4:0]  dest_q;
    logic        misaligned;
    logic        has_req;
    logic        need_req_in;
    logic        ready_go;
    logic        fwd;
    logic        load;

    assign misaligned  = op_misaligned(op_q, addr_q);
    assign has_req     = (op_is_load(op_q) || op_is_store(op_q)) && !misaligned;
    assign need_req_in = (op_is_load(in_op) || op_is_store(in_op)) &&
                         !op_misaligned(in_op, in_addr);

    // only a request still waiting for addr_ok holds the stage
    assign ready_go = !(state == REQ && !addr_ok);
    assign fwd      = valid_q && ready_go && out_ready;
    assign in_ready = !rst && (!valid_q || fwd);
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (fwd) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            pc_q    <= in_pc;
            addr_q  <= in_addr;
            wdata_q <= in_wdata;
            op_q    <= in_op;
            dest_q  <= in_dest;
        end
    end

    // SENT keeps an accepted request from going out again while stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else if (load) begin
            state <= need_req_in ? REQ : IDLE;
        end else if (fwd) begin
            state <= IDLE;
        end else if (state == REQ && addr_ok) begin
            state <= SENT;
        end
    end

    assign data_req  = (state == REQ);
    assign data_wr   = op_is_store(op_q);
    assign data_size = op_size(op_q);
    assign data_addr = addr_q;

    always_comb begin
        case (op_q)
            OP_ST_B: data_wstrb = 4'b0001 << addr_q[1:0];
            OP_ST_H: data_wstrb = addr_q[1] ? 4'b1100 : 4'b0011;
            OP_ST_W: data_wstrb = 4'b1111;
            default: data_wstrb = 4'b0000;
        endcase
    end

    // replicate store data across the byte lanes
    always_comb begin
        case (op_size(op_q))
            2'd0: data_wdata = {4{wdata_q[7:0]}};
            2'd1: data_wdata = {2{wdata_q[15:0]}};
            default: data_wdata = wdata_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (out_ready) begin
            out_valid <= valid_q && ready_go;
        end
    end

    always_ff @(posedge clk) begin
        if (fwd) begin
            out_pc      <= pc_q;
            out_result  <= addr_q;
            out_op      <= op_q;
            out_offset  <= addr_q[1:0];
            out_dest    <= dest_q;
            out_has_req <= has_req;
            out_exc     <= misaligned;
            out_ecode   <= misaligned ? ECODE_ALE : 6'd0;
        end
    end

    // request fields hold until the slave takes them
    assert property (@(posedge clk) disable iff (rst)
        data_req && !addr_ok |=> data_req && $stable(data_addr) && $stable(data_wr) &&
            $stable(data_size) && $stable(data_wstrb) && $stable(data_wdata));

endmodule

`default_nettype wire

// ==== mem_pipe_pkg.sv ====
`default_nettype none

package mem_pipe_pkg;

    typedef enum logic [3:0] {
        OP_ALU,
        OP_LD_B,
        OP_LD_BU,
        OP_LD_H,
        OP_LD_HU,
        OP_LD_W,
        OP_ST_B,
        OP_ST_H,
        OP_ST_W
    } mem_op_e;

    // address error on a misaligned load or store
    localparam logic [5:0] ECODE_ALE = 6'd9;

    function automatic logic op_is_load(mem_op_e op);
        return op inside {OP_LD_B, OP_LD_BU, OP_LD_H, OP_LD_HU, OP_LD_W};
    endfunction

    function automatic logic op_is_store(mem_op_e op);
        return op inside {OP_ST_B, OP_ST_H, OP_ST_W};
    endfunction

    // bus size encoding is 0 byte, 1 halfword, 2 word
    function automatic logic [1:0] op_size(mem_op_e op);
        case (op)
            OP_LD_B, OP_LD_BU, OP_ST_B: return 2'd0;
            OP_LD_H, OP_LD_HU, OP_ST_H: return 2'd1;
            default: return 2'd2;
        endcase
    endfunction

    function automatic logic op_misaligned(mem_op_e op, logic [31:0] addr);
        if (!(op_is_load(op) || op_is_store(op))) begin
            return 1'b0;
        end
        case (op_size(op))
            2'd1: return addr[0];
            2'd2: return addr[1:0] != 2'b00;
            default: return 1'b0;
        endcase
    endfunction

endpackage

`default_nettype wire
